//--- aer_geom_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Geometry of the event-camera pixel array and its 2 by 2 groups.
// Holds the array and group sizes, address widths and timestamp width,
// imported by every readout module that forms or decodes an address.
////////////////////////////////////////////////////////////////////////////

package aer_geom_pkg;

    // Array size
    localparam int NUM_ROWS     = 4;                      // Pixel rows
    localparam int NUM_COLS     = 4;                      // Pixel columns
    localparam int NUM_PIXELS   = NUM_ROWS * NUM_COLS;    // Pixels in the whole array

    // Group size
    localparam int GRP_ROWS     = 2;                      // Rows inside one group
    localparam int GRP_COLS     = 2;                      // Columns inside one group
    localparam int GRP_PIXELS   = GRP_ROWS * GRP_COLS;    // Pixels per group
    localparam int GRPS_PER_ROW = NUM_COLS / GRP_COLS;    // Groups side by side in a group row
    localparam int NUM_GROUPS   = 4;                      // Groups sharing the event bus

    // Address and stamp widths
    localparam int ROW_ADDR_W   = 2;                      // Row address bits
    localparam int COL_ADDR_W   = 2;                      // Column address bits
    localparam int GRP_IDX_W    = 2;                      // Group index bits
    localparam int PIX_IDX_W    = 2;                      // Local pixel index bits
    localparam int TS_W         = 12;                     // Timestamp bits, wraps

    typedef logic [ROW_ADDR_W-1:0] row_addr_t;            // Global pixel row
    typedef logic [COL_ADDR_W-1:0] col_addr_t;            // Global pixel column
    typedef logic [GRP_IDX_W-1:0]  grp_idx_t;             // Group number, grp row * 2 + grp col
    typedef logic [PIX_IDX_W-1:0]  pix_idx_t;             // Pixel inside a group, lrow * 2 + lcol
    typedef logic [TS_W-1:0]       timestamp_t;           // Free-running cycle count

    // Index of a pixel in the row-major request vector
    typedef logic [$clog2(NUM_PIXELS)-1:0] pix_addr_t;

endpackage

//--- aer_event_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Event word and pixel request types of the AER readout.
// A pixel request carries ON in bit 0 and OFF in bit 1; the event word
// packs row, column, timestamp and polarity for the output stream.
////////////////////////////////////////////////////////////////////////////

package aer_event_pkg;

    // One pixel's request pair
    typedef logic [1:0] pix_req_t;                        // [0] ON change, [1] OFF change

    localparam int REQ_ON_BIT  = 0;                       // Bit position of the ON request
    localparam int REQ_OFF_BIT = 1;                       // Bit position of the OFF request

    // Polarity of a reported event
    typedef enum logic
    {
        POL_OFF = 1'b0,                                   // Brightness went down
        POL_ON  = 1'b1                                    // Brightness went up
    } polarity_e;

    // Event word, 2 + 2 + 12 + 1 = 17 bits, row in the MSBs
    typedef struct packed
    {
        aer_geom_pkg::row_addr_t  row;                    // Pixel row
        aer_geom_pkg::col_addr_t  col;                    // Pixel column
        aer_geom_pkg::timestamp_t timestamp;              // Cycle count at grant
        polarity_e                polarity;               // ON or OFF
    } aer_event_t;

    localparam int EVENT_W = $bits(aer_event_t);          // Width of one event word

endpackage

//--- pixel_group_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Level-0 round-robin arbiter for one 2 by 2 pixel group.
// Picks the first requesting pixel at or after the pointer and reports
// its polarity; the pointer moves past the winner on advance_i.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pixel_group_arbiter
(
    input  logic                                                   clk_i     ,  // System clock
    input  logic                                                   reset_i   ,  // Async reset
    input  aer_event_pkg::pix_req_t [aer_geom_pkg::GRP_PIXELS-1:0] req_i     ,  // Group requests
    input  logic                                                   advance_i ,  // Group granted
    output logic                                                   has_req_o ,  // Any pixel asks
    output aer_geom_pkg::pix_idx_t                                 sel_o     ,  // Candidate pixel
    output aer_event_pkg::polarity_e                               sel_pol_o    // Its polarity
);

    import aer_geom_pkg::*;
    import aer_event_pkg::*;

    pix_idx_t ptr_q;                                      // Round-robin start point
    pix_idx_t sel;                                        // Winner of the search
    logic     found;                                      // Search hit something
    pix_req_t sel_req;                                    // Request bits of the winner

    // Search upward from the pointer, wrapping at the group size
    always_comb
    begin : search
        pix_idx_t cand;
        found = 1'b0;
        sel   = ptr_q;                                    // Default keeps the pointer
        cand  = ptr_q;
        for (int i = 0; i < GRP_PIXELS; i++)
        begin
            cand = pix_idx_t'(ptr_q + i);                 // Wraps through the 2-bit index
            if (!found && (req_i[cand] != '0))
            begin
                found = 1'b1;
                sel   = cand;
            end
        end
    end

    assign sel_req   = req_i[sel];
    assign has_req_o = found;
    assign sel_o     = sel;

    // ON wins when both bits are set
    assign sel_pol_o = sel_req[REQ_ON_BIT] ? POL_ON : POL_OFF;

    // Pointer moves to the pixel after the granted one
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ptr_q <= '0;                                  // Start at pixel 0
        end
        else if (advance_i && found)
        begin
            ptr_q <= pix_idx_t'(sel + 1'b1);              // Skip past the winner
        end
    end

endmodule

//--- group_level0.sv
////////////////////////////////////////////////////////////////////////////
// Level 0 of the readout: one round-robin arbiter per pixel group.
// Slices the row-major request array into groups, reports each group's
// request flag and candidate, and advances only the granted group.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module group_level0
(
    input  logic                                                   clk_i       ,  // System clock
    input  logic                                                   reset_i     ,  // Async reset
    input  aer_event_pkg::pix_req_t [aer_geom_pkg::NUM_PIXELS-1:0] req_i       ,  // Row-major
    input  logic                                                   grant_i     ,  // Bus grant
    input  aer_geom_pkg::grp_idx_t                                 grant_grp_i ,  // Granted group
    output logic [aer_geom_pkg::NUM_GROUPS-1:0]                    grp_req_o   ,  // Group asks
    output aer_geom_pkg::pix_idx_t [aer_geom_pkg::NUM_GROUPS-1:0]  local_sel_o ,  // Candidates
    output aer_event_pkg::polarity_e [aer_geom_pkg::NUM_GROUPS-1:0] local_pol_o   // Polarities
);

    import aer_geom_pkg::*;
    import aer_event_pkg::*;

    pix_req_t [NUM_GROUPS-1:0][GRP_PIXELS-1:0] grp_pix;  // Requests regrouped per group
    logic     [NUM_GROUPS-1:0]                 advance;  // Pointer step per group

    for (genvar g = 0; g < NUM_GROUPS; g++)
    begin : g_group
        // Map local pixel l of group g to its row-major position
        for (genvar l = 0; l < GRP_PIXELS; l++)
        begin : g_pix
            localparam int ROW = (g / GRPS_PER_ROW) * GRP_ROWS + l / GRP_COLS;
            localparam int COL = (g % GRPS_PER_ROW) * GRP_COLS + l % GRP_COLS;
            assign grp_pix[g][l] = req_i[ROW * NUM_COLS + COL];
        end

        assign advance[g] = grant_i && (grant_grp_i == grp_idx_t'(g));  // Only the winner steps

        pixel_group_arbiter u_pixel_group_arbiter
        (
            .clk_i     (clk_i)          ,
            .reset_i   (reset_i)        ,
            .req_i     (grp_pix[g])     ,
            .advance_i (advance[g])     ,
            .has_req_o (grp_req_o[g])   ,
            .sel_o     (local_sel_o[g]) ,
            .sel_pol_o (local_pol_o[g])
        );
    end

endmodule

//--- bus_group_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Level-1 arbiter that hands the shared event bus to one pixel group.
// The owning group keeps the bus until it has no requests left; then the
// next requesting group after it, round-robin, takes over.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module bus_group_arbiter
(
    input  logic                                clk_i       ,  // System clock
    input  logic                                reset_i     ,  // Async reset
    input  logic [aer_geom_pkg::NUM_GROUPS-1:0] grp_req_i   ,  // Per-group request flags
    input  logic                                accept_i    ,  // Encoder can take an event
    output logic                                grant_o     ,  // Grant strobe
    output aer_geom_pkg::grp_idx_t              grant_grp_o    // Selected group
);

    import aer_geom_pkg::*;

    grp_idx_t owner_q;                                    // Group holding the bus
    grp_idx_t sel;                                        // Group chosen this cycle
    logic     any_req;                                    // Some group asks

    assign any_req = |grp_req_i;

    // Owner keeps the bus while it requests, else next requester after it
    always_comb
    begin : choose
        grp_idx_t cand;
        logic     found;
        sel   = owner_q;
        cand  = owner_q;
        found = grp_req_i[owner_q];                       // Group release not reached yet
        for (int i = 1; i < NUM_GROUPS; i++)
        begin
            cand = grp_idx_t'(owner_q + i);               // Wraps over the group count
            if (!found && grp_req_i[cand])
            begin
                found = 1'b1;
                sel   = cand;
            end
        end
    end

    assign grant_o     = any_req && accept_i && !reset_i; // Out of reset and output has room
    assign grant_grp_o = sel;

    // Ownership follows every grant
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            owner_q <= '0;                                // Group 0 holds the bus first
        end
        else if (grant_o)
        begin
            owner_q <= sel;
        end
    end

endmodule

//--- event_encoder.sv
////////////////////////////////////////////////////////////////////////////
// Event encoder: free-running timestamp and the registered event output.
// Loads row, column, current timestamp and polarity on load_i and holds
// the word with valid high until a valid/ready transfer empties it.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module event_encoder
(
    input  logic                      clk_i         ,  // System clock
    input  logic                      reset_i       ,  // Async reset
    input  logic                      load_i        ,  // Grant strobe, load new event
    input  aer_geom_pkg::row_addr_t   row_i         ,  // Granted pixel row
    input  aer_geom_pkg::col_addr_t   col_i         ,  // Granted pixel column
    input  aer_event_pkg::polarity_e  pol_i         ,  // Granted pixel polarity
    input  logic                      ready_i       ,  // Sink takes the event
    output logic                      accept_o      ,  // Room for a new event
    output aer_event_pkg::aer_event_t event_o       ,  // Event word
    output logic                      event_valid_o    // Event word valid
);

    import aer_geom_pkg::*;
    import aer_event_pkg::*;

    timestamp_t ts_q;                                     // Cycle counter
    aer_event_t event_q;                                  // Output payload
    logic       valid_q;                                  // Output register full

    // Counter reads 0 in the first cycle after reset and wraps at TS_W
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ts_q <= '0;
        end
        else
        begin
            ts_q <= ts_q + 1'b1;
        end
    end

    // Register empty, or emptied by a transfer this cycle
    assign accept_o = !valid_q || ready_i;

    // Valid flag
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            valid_q <= 1'b0;
        end
        else if (load_i)
        begin
            valid_q <= 1'b1;                              // New word replaces or fills
        end
        else if (ready_i)
        begin
            valid_q <= 1'b0;                              // Transfer done, nothing behind it
        end
    end

    // Payload, stamped with the grant-cycle count
    always_ff @(posedge clk_i)
    begin
        if (load_i)
        begin
            event_q.row       <= row_i;
            event_q.col       <= col_i;
            event_q.timestamp <= ts_q;
            event_q.polarity  <= pol_i;
        end
    end

    assign event_o       = event_q;
    assign event_valid_o = valid_q;

endmodule

//--- aer_readout_top.sv
////////////////////////////////////////////////////////////////////////////
// Top of the two-level AER readout for the 4 by 4 event-camera array.
// Connects the group arbiters, the bus arbiter and the event encoder,
// forms the global address and drives the one-hot pixel grant.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module aer_readout_top
(
    input  logic                                                   clk_i         ,  // Clock
    input  logic                                                   reset_i       ,  // Async reset
    input  aer_event_pkg::pix_req_t [aer_geom_pkg::NUM_PIXELS-1:0] req_i         ,  // Row-major
    output logic [aer_geom_pkg::NUM_PIXELS-1:0]                    gnt_o         ,  // One-hot
    output aer_event_pkg::aer_event_t                              event_o       ,  // Event
    output logic                                                   event_valid_o ,  // Valid
    input  logic                                                   event_ready_i    // Ready
);

    import aer_geom_pkg::*;
    import aer_event_pkg::*;

    logic      [NUM_GROUPS-1:0] grp_req;                  // Group has a request
    pix_idx_t  [NUM_GROUPS-1:0] local_sel;                // Candidate per group
    polarity_e [NUM_GROUPS-1:0] local_pol;                // Candidate polarity per group
    logic                       grant;                    // Bus grant strobe
    grp_idx_t                   grant_grp;                // Group owning this grant
    logic                       accept;                   // Encoder has room
    pix_idx_t                   win_local;                // Winner inside its group
    row_addr_t                  win_row;                  // Winner global row
    col_addr_t                  win_col;                  // Winner global column
    pix_addr_t                  win_addr;                 // Winner row-major index

    group_level0 u_group_level0
    (
        .clk_i       (clk_i)     ,
        .reset_i     (reset_i)   ,
        .req_i       (req_i)     ,
        .grant_i     (grant)     ,
        .grant_grp_i (grant_grp) ,
        .grp_req_o   (grp_req)   ,
        .local_sel_o (local_sel) ,
        .local_pol_o (local_pol)
    );

    bus_group_arbiter u_bus_group_arbiter
    (
        .clk_i       (clk_i)     ,
        .reset_i     (reset_i)   ,
        .grp_req_i   (grp_req)   ,
        .accept_i    (accept)    ,
        .grant_o     (grant)     ,
        .grant_grp_o (grant_grp)
    );

    // Group position plus local position gives the array address
    assign win_local = local_sel[grant_grp];
    assign win_row   = row_addr_t'((grant_grp / GRPS_PER_ROW) * GRP_ROWS + win_local / GRP_COLS);
    assign win_col   = col_addr_t'((grant_grp % GRPS_PER_ROW) * GRP_COLS + win_local % GRP_COLS);
    assign win_addr  = pix_addr_t'(win_row * NUM_COLS + win_col);

    // Grant pulse to the winning pixel only
    always_comb
    begin
        gnt_o = '0;
        if (grant)
        begin
            gnt_o[win_addr] = 1'b1;
        end
    end

    event_encoder u_event_encoder
    (
        .clk_i         (clk_i)                ,
        .reset_i       (reset_i)              ,
        .load_i        (grant)                ,
        .row_i         (win_row)              ,
        .col_i         (win_col)              ,
        .pol_i         (local_pol[grant_grp]) ,
        .ready_i       (event_ready_i)        ,
        .accept_o      (accept)               ,
        .event_o       (event_o)              ,
        .event_valid_o (event_valid_o)
    );

endmodule

//--- tb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset source for the AER readout testbench.
// 100 ns clock, reset held high for 16 rising edges, then released.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clock_gen
(
    output logic clk_o   ,  // Testbench clock
    output logic reset_o    // Active-high reset
);

    localparam int HALF_PERIOD  = 50;                     // 100 ns period
    localparam int RESET_CYCLES = 16;                     // Rising edges under reset
    localparam int RELEASE_SKEW = 5;                      // Release just after the edge

    initial
    begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial
    begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #RELEASE_SKEW reset_o = 1'b0;                     // First free cycle starts here
    end

endmodule

//--- aer_readout_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the two-level AER readout of the 4 by 4 pixel array.
// Random pixel requests and random ready drive the DUT; a cycle model of
// both round-robin levels and the output register predicts every output.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module aer_readout_tb;

    import aer_geom_pkg::*;
    import aer_event_pkg::*;

    localparam int DRIVE_DELAY   = 10;                    // Input skew after the rising edge
    localparam int SAMPLE_DELAY  = 30;                    // Settling before outputs are sampled
    localparam int READY_PCT     = 70;                    // Sink ready rate
    localparam int EVENT_TIMEOUT = 200;                   // Cycles without a transfer
    localparam int RESET_LIMIT   = 40;                    // Bound on the reset wait
    localparam int RANDOM_CYCLES = 4500;                  // Long enough to wrap the stamp
    localparam int DRAIN_LIMIT   = 400;                   // Bound on each drain
    localparam int NUM_BURSTS    = 4;

    logic                        clk;
    logic                        reset;
    pix_req_t [NUM_PIXELS-1:0]   req;                     // Pixel requests, row-major
    logic                        event_ready;
    logic     [NUM_PIXELS-1:0]   gnt;
    aer_event_t                  dut_event;
    logic                        dut_valid;

    pix_idx_t                    m_ptr [NUM_GROUPS];      // Model group pointers
    grp_idx_t                    m_owner;                 // Model bus owner
    logic                        m_valid;                 // Model output register full
    aer_event_t                  m_event;                 // Model output word
    timestamp_t                  m_ts;                    // Model cycle count
    logic     [NUM_PIXELS-1:0]   m_granted;               // Pixels to clear on next drive
    aer_event_t                  exp_q [$];               // Granted events in grant order

    logic                        prev_valid;              // Last cycle's valid
    logic                        prev_ready;              // Last cycle's ready
    aer_event_t                  prev_event;              // Last cycle's word

    int                          new_req_pct;             // New request chance per idle pixel
    logic                        burst_inject;            // Next drive sets every pixel
    int                          burst_first;             // Owner when the burst starts
    int                          burst_index;             // Grants seen in the burst
    int                          burst_left;
    int                          idle_cycles;             // Cycles since the last transfer
    int                          grants;
    int                          transfers;

    tb_clock_gen u_tb_clock_gen
    (
        .clk_o   (clk)   ,
        .reset_o (reset)
    );

    aer_readout_top u_aer_readout_top
    (
        .clk_i         (clk)         ,
        .reset_i       (reset)       ,
        .req_i         (req)         ,
        .gnt_o         (gnt)         ,
        .event_o       (dut_event)   ,
        .event_valid_o (dut_valid)   ,
        .event_ready_i (event_ready)
    );

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                     $time);
            stop_on_error();
        end
    endtask

    // Group g, local index l to row-major pixel index
    function automatic int pixel_of(input int g, input int l);
        int row;
        int col;
        row = (g / GRPS_PER_ROW) * GRP_ROWS + l / GRP_COLS;
        col = (g % GRPS_PER_ROW) * GRP_COLS + l % GRP_COLS;
        return row * NUM_COLS + col;
    endfunction

    // Group of the granted pixel, -1 when nothing is granted
    function automatic int group_of_grant(input logic [NUM_PIXELS-1:0] v);
        int grp;
        grp = -1;
        for (int p = 0; p < NUM_PIXELS; p++)
        begin
            if (v[p])
            begin
                grp = ((p / NUM_COLS) / GRP_ROWS) * GRPS_PER_ROW + (p % NUM_COLS) / GRP_COLS;
            end
        end
        return grp;
    endfunction

    function automatic logic pending_work();
        return (req != '0) || m_valid;
    endfunction

    // Pixel model: clear after grant, else maybe raise a new request
    task automatic drive_inputs();
        for (int p = 0; p < NUM_PIXELS; p++)
        begin
            if (m_granted[p])
            begin
                req[p] = 2'b00;                           // Dropped the cycle after its grant
            end
            else if (burst_inject || ((req[p] == 2'b00) && ($urandom_range(99) < new_req_pct)))
            begin
                req[p] = pix_req_t'($urandom_range(3, 1));
            end
        end
        m_granted    = '0;
        burst_inject = 1'b0;
        event_ready  = ($urandom_range(99) < READY_PCT);
    endtask

    // One cycle of the reference model, checks first, then state update
    task automatic model_step();
        logic [NUM_GROUPS-1:0] has;
        logic                  accept;
        logic                  grant;
        logic                  found;
        logic [NUM_PIXELS-1:0] exp_gnt;
        int                    g;
        int                    l;
        int                    p;
        int                    cand;
        int                    exp_grp;
        aer_event_t            ev;
        has = '0;
        for (int gi = 0; gi < NUM_GROUPS; gi++)
        begin
            for (int li = 0; li < GRP_PIXELS; li++)
            begin
                if (req[pixel_of(gi, li)] != 2'b00)
                begin
                    has[gi] = 1'b1;
                end
            end
        end
        accept  = !m_valid || event_ready;                // Empty or emptied this cycle
        grant   = (has != '0) && accept;
        exp_gnt = '0;
        g       = int'(m_owner);
        l       = 0;
        p       = 0;
        if (grant)
        begin
            found = has[g];                               // Owner keeps the bus
            for (int i = 1; i < NUM_GROUPS; i++)
            begin
                cand = (int'(m_owner) + i) % NUM_GROUPS;
                if (!found && has[cand])
                begin
                    found = 1'b1;
                    g     = cand;
                end
            end
            found = 1'b0;
            for (int i = 0; i < GRP_PIXELS; i++)
            begin
                cand = (int'(m_ptr[g]) + i) % GRP_PIXELS;  // Upward from the pointer
                if (!found && (req[pixel_of(g, cand)] != 2'b00))
                begin
                    found = 1'b1;
                    l     = cand;
                end
            end
            p          = pixel_of(g, l);
            exp_gnt[p] = 1'b1;
        end

        check_value("gnt_o one-hot", 32'($countones(gnt) <= 1), 32'd1);
        check_value("gnt_o", 32'(gnt), 32'(exp_gnt));
        check_value("event_valid_o", 32'(dut_valid), 32'(m_valid));
        if (m_valid)
        begin
            check_value("event_o", 32'(dut_event), 32'(m_event));
        end
        if (prev_valid && !prev_ready)                    // Stalled word must hold
        begin
            check_value("event_valid_o hold", 32'(dut_valid), 32'd1);
            check_value("event_o hold", 32'(dut_event), 32'(prev_event));
        end
        if (m_valid && !event_ready)
        begin
            check_value("gnt_o under back-pressure", 32'(gnt), 32'd0);
        end
        if (grant && (burst_left > 0))
        begin
            exp_grp = (burst_first + burst_index / GRP_PIXELS) % NUM_GROUPS;
            check_value("burst gnt_o group", 32'(group_of_grant(gnt)), 32'(exp_grp));
            burst_index++;
            burst_left--;
        end

        // Transfer against the grant-order scoreboard
        if (dut_valid && event_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("An event was transferred at %0t with no grant waiting for it", $time);
                stop_on_error();
            end
            ev = exp_q.pop_front();
            check_value("event_o at transfer", 32'(dut_event), 32'(ev));
            transfers++;
            idle_cycles = 0;
        end
        else if (pending_work())
        begin
            idle_cycles++;
        end
        else
        begin
            idle_cycles = 0;
        end
        if (idle_cycles > EVENT_TIMEOUT)
        begin
            $display("No event came out within %0d cycles while requests were pending",
                     EVENT_TIMEOUT);
            stop_on_error();
        end

        prev_valid = dut_valid;
        prev_ready = event_ready;
        prev_event = dut_event;

        if (grant)
        begin
            ev.row       = row_addr_t'(p / NUM_COLS);
            ev.col       = col_addr_t'(p % NUM_COLS);
            ev.timestamp = m_ts;                          // Stamp of the grant cycle
            ev.polarity  = req[p][REQ_ON_BIT] ? POL_ON : POL_OFF;  // ON wins
            m_event      = ev;
            m_valid      = 1'b1;
            exp_q.push_back(ev);
            m_ptr[g]     = pix_idx_t'((l + 1) % GRP_PIXELS);
            m_owner      = grp_idx_t'(g);
            m_granted[p] = 1'b1;
            grants++;
        end
        else if (event_ready)
        begin
            m_valid = 1'b0;
        end
        m_ts = timestamp_t'(m_ts + 1);                    // Wraps at TS_W bits
    endtask

    task automatic run_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        drive_inputs();
        #SAMPLE_DELAY;
        if (reset)
        begin
            check_value("event_valid_o in reset", 32'(dut_valid), 32'd0);
            check_value("gnt_o in reset", 32'(gnt), 32'd0);
        end
        else
        begin
            model_step();
        end
    endtask

    // Run at least one cycle, then until nothing is left to serve
    task automatic drain_requests(input string phase);
        int n;
        n = 0;
        do
        begin
            run_cycle();
            n++;
        end
        while (pending_work() && (n < DRAIN_LIMIT));
        if (pending_work())
        begin
            $display("Requests were still pending %0d cycles into the %s drain", n, phase);
            stop_on_error();
        end
    endtask

    initial
    begin : main
        int n;
        void'($urandom(51092));
        req          = '0;
        event_ready  = 1'b0;
        m_owner      = '0;
        m_valid      = 1'b0;
        m_event      = '0;
        m_ts         = '0;
        m_granted    = '0;
        prev_valid   = 1'b0;
        prev_ready   = 1'b0;
        prev_event   = '0;
        new_req_pct  = 0;
        burst_inject = 1'b0;
        burst_first  = 0;
        burst_index  = 0;
        burst_left   = 0;
        idle_cycles  = 0;
        grants       = 0;
        transfers    = 0;
        for (int g = 0; g < NUM_GROUPS; g++)
        begin
            m_ptr[g] = '0;                                // Every group starts at pixel 0
        end
        #1;

        // Reset, quiet first, then with requests already present
        n = 0;
        while (reset && (n < RESET_LIMIT))
        begin
            if (n == 8)
            begin
                new_req_pct = 25;
            end
            run_cycle();
            n++;
        end
        if (reset)
        begin
            $display("Reset was not released within %0d cycles", RESET_LIMIT);
            stop_on_error();
        end

        // Random traffic under random back-pressure
        new_req_pct = 6;
        for (int i = 0; i < RANDOM_CYCLES; i++)
        begin
            run_cycle();
        end
        new_req_pct = 0;
        drain_requests("random");

        // Full-array bursts, groups must leave in runs of four
        for (int b = 0; b < NUM_BURSTS; b++)
        begin
            burst_first  = int'(m_owner);
            burst_index  = 0;
            burst_left   = NUM_PIXELS;
            burst_inject = 1'b1;
            drain_requests("burst");
            check_value("burst grant count", 32'(burst_index), 32'(NUM_PIXELS));
        end

        // Last random stretch and the final drain
        new_req_pct = 10;
        for (int i = 0; i < 300; i++)
        begin
            run_cycle();
        end
        new_req_pct = 0;
        drain_requests("final");
        check_value("events left unsent", 32'(exp_q.size()), 32'd0);
        check_value("transfers against grants", 32'(transfers), 32'(grants));

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- sim.f
aer_geom_pkg.sv
aer_event_pkg.sv
pixel_group_arbiter.sv
group_level0.sv
bus_group_arbiter.sv
event_encoder.sv
aer_readout_top.sv
tb_clock_gen.sv
aer_readout_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the AER readout testbench with Verilator and run it.
# The run passes only when the log holds the pass line of the testbench.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 -f sim.f --top-module aer_readout_tb -o aer_readout_sim

./obj_dir/aer_readout_sim | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
